//--- hw/gpu_regs_defs.svh
`ifndef GPU_REGS_DEFS_SVH
`define GPU_REGS_DEFS_SVH

// --------------------------------------------------
// axi4-lite bus geometry
// --------------------------------------------------
`define GPU_REGS_DATA_W    32
`define GPU_REGS_ADDR_W    7

// word index sits above the byte offset
`define GPU_REGS_ADDR_LSB  2
`define GPU_REGS_IDX_W     5

// --------------------------------------------------
// register map
// --------------------------------------------------
`define GPU_REGS_NUM_CTRL  16 // indices 0 to 15, read/write
`define GPU_REGS_NUM_STAT  16 // indices 16 to 31, read only

`endif

//--- hw/gpu_regs_pkg.sv
`include "gpu_regs_defs.svh"

package gpu_regs_pkg;

	// bus payloads
	typedef logic [`GPU_REGS_DATA_W-1:0]   axi_data_t;
	typedef logic [`GPU_REGS_ADDR_W-1:0]   axi_addr_t;
	typedef logic [`GPU_REGS_DATA_W/8-1:0] axi_strb_t;

	// top bit picks the status half
	typedef logic [`GPU_REGS_IDX_W-1:0] reg_idx_t;

	// response codes as on the bus, only OKAY is produced
	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

	// sixteen words side by side, control bank and status inputs alike
	typedef axi_data_t [`GPU_REGS_NUM_CTRL-1:0] reg_bank_t;

endpackage

//--- hw/gpu_regs_write_ctrl.sv
`timescale 1ns/100ps
`include "gpu_regs_defs.svh"

module gpu_regs_write_ctrl
(
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,

	input  gpu_regs_pkg::axi_addr_t  i_awaddr,
	input  logic                     i_awvalid,
	output logic                     o_awready,

	input  logic                     i_wvalid,
	output logic                     o_wready,

	output gpu_regs_pkg::axi_resp_t  o_bresp,
	output logic                     o_bvalid,
	input  logic                     i_bready,

	output logic                     o_wr_en,
	output gpu_regs_pkg::reg_idx_t   o_wr_idx
);

	logic                   aw_en;     // high while no write is outstanding
	logic                   ready_q;   // shared aw/w ready pulse
	logic                   bvalid_q;
	logic                   accept;
	gpu_regs_pkg::reg_idx_t wr_idx_q;

	// --------------------------------------------------
	// address and data accepted together
	// --------------------------------------------------
	assign accept = aw_en && !ready_q && i_awvalid && i_wvalid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			ready_q  <= 1'b0;
			aw_en    <= 1'b1;
			bvalid_q <= 1'b0;
		end
		else
		begin
			ready_q <= accept; // one cycle only

			if (accept)
				aw_en <= 1'b0;
			else if (bvalid_q && i_bready)
				aw_en <= 1'b1; // B done, next write may start

			if (o_wr_en)
				bvalid_q <= 1'b1;
			else if (i_bready)
				bvalid_q <= 1'b0;
		end
	end

	// word index captured as the readies rise
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
			wr_idx_q <= i_awaddr[`GPU_REGS_ADDR_LSB +: `GPU_REGS_IDX_W];
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------
	assign o_awready = ready_q;
	assign o_wready  = ready_q;
	assign o_wr_en   = ready_q && i_awvalid && i_wvalid;
	assign o_wr_idx  = wr_idx_q;
	assign o_bvalid  = bvalid_q;
	assign o_bresp   = gpu_regs_pkg::OKAY;

endmodule

//--- hw/gpu_regs_ctrl_bank.sv
`timescale 1ns/100ps
`include "gpu_regs_defs.svh"

module gpu_regs_ctrl_bank
(
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,

	input  logic                     i_wr_en,
	input  gpu_regs_pkg::reg_idx_t   i_wr_idx,
	input  gpu_regs_pkg::axi_data_t  i_wdata,
	input  gpu_regs_pkg::axi_strb_t  i_wstrb,

	output gpu_regs_pkg::reg_bank_t  o_ctrl_regs
);

	logic ctrl_hit; // index lands in the control half

	assign ctrl_hit = (i_wr_idx < `GPU_REGS_NUM_CTRL);

	// --------------------------------------------------
	// byte-lane merge into the addressed register
	// --------------------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_ctrl_regs <= '0;
		end
		else if (i_wr_en && ctrl_hit)
		begin
			for (int b = 0; b < `GPU_REGS_DATA_W/8; b++)
			begin
				if (i_wstrb[b])
					o_ctrl_regs[i_wr_idx[`GPU_REGS_IDX_W-2:0]][b*8 +: 8] <= i_wdata[b*8 +: 8];
			end
		end
		// status indices fall through untouched
	end

endmodule

//--- hw/gpu_regs_read_ctrl.sv
`timescale 1ns/100ps
`include "gpu_regs_defs.svh"

module gpu_regs_read_ctrl
(
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,

	input  gpu_regs_pkg::axi_addr_t  i_araddr,
	input  logic                     i_arvalid,
	output logic                     o_arready,

	output gpu_regs_pkg::axi_data_t  o_rdata,
	output gpu_regs_pkg::axi_resp_t  o_rresp,
	output logic                     o_rvalid,
	input  logic                     i_rready,

	input  gpu_regs_pkg::reg_bank_t  i_ctrl_regs,
	input  gpu_regs_pkg::reg_bank_t  i_status
);

	logic                    arready_q;
	logic                    rvalid_q;
	logic                    ar_accept;
	logic                    rd_en;
	gpu_regs_pkg::reg_idx_t  rd_idx_q;
	gpu_regs_pkg::axi_data_t rd_word;
	gpu_regs_pkg::axi_data_t rdata_q;

	// --------------------------------------------------
	// AR handshake, one read in flight
	// --------------------------------------------------
	// a pending response blocks the next address
	assign ar_accept = i_arvalid && !arready_q && !rvalid_q;
	assign rd_en     = arready_q && i_arvalid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end
		else
		begin
			arready_q <= ar_accept;

			if (rd_en)
				rvalid_q <= 1'b1;
			else if (i_rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_accept)
			rd_idx_q <= i_araddr[`GPU_REGS_ADDR_LSB +: `GPU_REGS_IDX_W];
	end

	// --------------------------------------------------
	// word select and registered read data
	// --------------------------------------------------
	always_comb
	begin
		if (rd_idx_q[`GPU_REGS_IDX_W-1])
			rd_word = i_status[rd_idx_q[`GPU_REGS_IDX_W-2:0]];    // status half
		else
			rd_word = i_ctrl_regs[rd_idx_q[`GPU_REGS_IDX_W-2:0]];
	end

	// status is sampled here, in the cycle after the address
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_en)
			rdata_q <= rd_word;
	end

	assign o_arready = arready_q;
	assign o_rvalid  = rvalid_q;
	assign o_rdata   = rdata_q;
	assign o_rresp   = gpu_regs_pkg::OKAY;

endmodule

//--- hw/gpu_regs_top.sv
`timescale 1ns/100ps
`include "gpu_regs_defs.svh"

module gpu_regs_top
(
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,

	// write address and data
	input  gpu_regs_pkg::axi_addr_t  S_AXI_AWADDR,
	input  logic                     S_AXI_AWVALID,
	output logic                     S_AXI_AWREADY,
	input  gpu_regs_pkg::axi_data_t  S_AXI_WDATA,
	input  gpu_regs_pkg::axi_strb_t  S_AXI_WSTRB,
	input  logic                     S_AXI_WVALID,
	output logic                     S_AXI_WREADY,

	// write response
	output gpu_regs_pkg::axi_resp_t  S_AXI_BRESP,
	output logic                     S_AXI_BVALID,
	input  logic                     S_AXI_BREADY,

	// read
	input  gpu_regs_pkg::axi_addr_t  S_AXI_ARADDR,
	input  logic                     S_AXI_ARVALID,
	output logic                     S_AXI_ARREADY,
	output gpu_regs_pkg::axi_data_t  S_AXI_RDATA,
	output gpu_regs_pkg::axi_resp_t  S_AXI_RRESP,
	output logic                     S_AXI_RVALID,
	input  logic                     S_AXI_RREADY,

	// accelerator side
	output gpu_regs_pkg::reg_bank_t  o_ctrl_regs,
	input  gpu_regs_pkg::reg_bank_t  i_status
);

	logic                   wr_en;
	gpu_regs_pkg::reg_idx_t wr_idx;

	gpu_regs_write_ctrl u_write_ctrl
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awaddr      (S_AXI_AWADDR),
		.i_awvalid     (S_AXI_AWVALID),
		.o_awready     (S_AXI_AWREADY),
		.i_wvalid      (S_AXI_WVALID),
		.o_wready      (S_AXI_WREADY),
		.o_bresp       (S_AXI_BRESP),
		.o_bvalid      (S_AXI_BVALID),
		.i_bready      (S_AXI_BREADY),
		.o_wr_en       (wr_en),
		.o_wr_idx      (wr_idx)
	);

	gpu_regs_ctrl_bank u_ctrl_bank
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_wr_en       (wr_en),
		.i_wr_idx      (wr_idx),
		.i_wdata       (S_AXI_WDATA),
		.i_wstrb       (S_AXI_WSTRB),
		.o_ctrl_regs   (o_ctrl_regs)
	);

	// reads see the bank as driven to the accelerator
	gpu_regs_read_ctrl u_read_ctrl
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_araddr      (S_AXI_ARADDR),
		.i_arvalid     (S_AXI_ARVALID),
		.o_arready     (S_AXI_ARREADY),
		.o_rdata       (S_AXI_RDATA),
		.o_rresp       (S_AXI_RRESP),
		.o_rvalid      (S_AXI_RVALID),
		.i_rready      (S_AXI_RREADY),
		.i_ctrl_regs   (o_ctrl_regs),
		.i_status      (i_status)
	);

endmodule

//--- verif/gpu_regs_asserts.sv
`timescale 1ns/100ps
`include "gpu_regs_defs.svh"

module gpu_regs_asserts
(
	input logic                    S_AXI_ACLK,
	input logic                    S_AXI_ARESETN,
	input logic                    S_AXI_AWREADY,
	input logic                    S_AXI_WREADY,
	input gpu_regs_pkg::axi_resp_t S_AXI_BRESP,
	input logic                    S_AXI_BVALID,
	input logic                    S_AXI_BREADY,
	input gpu_regs_pkg::axi_data_t S_AXI_RDATA,
	input gpu_regs_pkg::axi_resp_t S_AXI_RRESP,
	input logic                    S_AXI_RVALID,
	input logic                    S_AXI_RREADY
);

	int assert_errors = 0; // read by the testbench for its totals

	// --------------------------------------------------
	// write channel
	// --------------------------------------------------
	awready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY |=> !S_AXI_AWREADY)
		else begin assert_errors++; $error("AWREADY high for more than one cycle"); end

	wready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_WREADY |=> !S_AXI_WREADY)
		else begin assert_errors++; $error("WREADY high for more than one cycle"); end

	bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
		else begin assert_errors++; $error("BVALID dropped before BREADY"); end

	bresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID |-> S_AXI_BRESP == gpu_regs_pkg::OKAY)
		else begin assert_errors++; $error("BRESP is not OKAY"); end

	// --------------------------------------------------
	// read channel
	// --------------------------------------------------
	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
		else begin assert_errors++; $error("RVALID or RDATA changed before RREADY"); end

	rresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID |-> S_AXI_RRESP == gpu_regs_pkg::OKAY)
		else begin assert_errors++; $error("RRESP is not OKAY"); end

endmodule

bind gpu_regs_top gpu_regs_asserts u_asserts
(
	.S_AXI_ACLK    (S_AXI_ACLK),
	.S_AXI_ARESETN (S_AXI_ARESETN),
	.S_AXI_AWREADY (S_AXI_AWREADY),
	.S_AXI_WREADY  (S_AXI_WREADY),
	.S_AXI_BRESP   (S_AXI_BRESP),
	.S_AXI_BVALID  (S_AXI_BVALID),
	.S_AXI_BREADY  (S_AXI_BREADY),
	.S_AXI_RDATA   (S_AXI_RDATA),
	.S_AXI_RRESP   (S_AXI_RRESP),
	.S_AXI_RVALID  (S_AXI_RVALID),
	.S_AXI_RREADY  (S_AXI_RREADY)
);

//--- verif/gpu_regs_tb.sv
`timescale 1ns/100ps
`include "gpu_regs_defs.svh"

module gpu_regs_tb;

	localparam int WAIT_LIMIT = 64;

	logic                    S_AXI_ACLK;
	logic                    S_AXI_ARESETN;
	gpu_regs_pkg::axi_addr_t S_AXI_AWADDR, S_AXI_ARADDR;
	logic                    S_AXI_AWVALID, S_AXI_AWREADY;
	gpu_regs_pkg::axi_data_t S_AXI_WDATA, S_AXI_RDATA;
	gpu_regs_pkg::axi_strb_t S_AXI_WSTRB;
	logic                    S_AXI_WVALID, S_AXI_WREADY;
	gpu_regs_pkg::axi_resp_t S_AXI_BRESP, S_AXI_RRESP;
	logic                    S_AXI_BVALID, S_AXI_BREADY;
	logic                    S_AXI_ARVALID, S_AXI_ARREADY;
	logic                    S_AXI_RVALID, S_AXI_RREADY;
	gpu_regs_pkg::reg_bank_t o_ctrl_regs;
	gpu_regs_pkg::reg_bank_t status_words; // drives i_status

	gpu_regs_pkg::reg_bank_t mirror; // expected control bank
	logic [31:0]             lfsr_state = 32'h1cded24c;
	gpu_regs_pkg::axi_data_t got_q[$], exp_q[$];
	string                   name_q[$];
	int                      errors = 0, checks = 0, test_count = 0, test_err_start = 0;

	gpu_regs_top dut_i
	(
		.S_AXI_ACLK (S_AXI_ACLK), .S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR (S_AXI_AWADDR), .S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY), .S_AXI_WDATA (S_AXI_WDATA),
		.S_AXI_WSTRB (S_AXI_WSTRB), .S_AXI_WVALID (S_AXI_WVALID),
		.S_AXI_WREADY (S_AXI_WREADY), .S_AXI_BRESP (S_AXI_BRESP),
		.S_AXI_BVALID (S_AXI_BVALID), .S_AXI_BREADY (S_AXI_BREADY),
		.S_AXI_ARADDR (S_AXI_ARADDR), .S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY), .S_AXI_RDATA (S_AXI_RDATA),
		.S_AXI_RRESP (S_AXI_RRESP), .S_AXI_RVALID (S_AXI_RVALID),
		.S_AXI_RREADY (S_AXI_RREADY), .o_ctrl_regs (o_ctrl_regs),
		.i_status (status_words)
	);

	initial S_AXI_ACLK = 1'b0;
	always #2 S_AXI_ACLK = ~S_AXI_ACLK;

	// --------------------------------------------------
	// random numbers and reference model
	// --------------------------------------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
		end
		return r;
	endfunction

	// strobed bytes replace old ones, status indices leave the bank alone
	function automatic gpu_regs_pkg::reg_bank_t ref_bank_write(input gpu_regs_pkg::reg_bank_t bank,
		input int idx, input gpu_regs_pkg::axi_data_t data, input gpu_regs_pkg::axi_strb_t strb);
		gpu_regs_pkg::reg_bank_t nb = bank;
		if (idx < `GPU_REGS_NUM_CTRL)
			for (int b = 0; b < 4; b++)
				if (strb[b])
					nb[idx][b*8 +: 8] = data[b*8 +: 8];
		return nb;
	endfunction

	function automatic gpu_regs_pkg::axi_data_t expected_read(input int idx);
		return (idx < `GPU_REGS_NUM_CTRL) ? mirror[idx] : status_words[idx - `GPU_REGS_NUM_CTRL];
	endfunction

	function automatic int total_errors();
		return errors + dut_i.u_asserts.assert_errors;
	endfunction

	function automatic void expect_word(input gpu_regs_pkg::axi_data_t got,
		input gpu_regs_pkg::axi_data_t exp, input string name);
		got_q.push_back(got);
		exp_q.push_back(exp);
		name_q.push_back(name);
	endfunction

	// comparison process, drains whatever the tasks queued
	always @(posedge S_AXI_ACLK)
	begin : compare
		gpu_regs_pkg::axi_data_t got, exp;
		string name;
		while (got_q.size() > 0)
		begin
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			name = name_q.pop_front();
			checks++;
			assert (got === exp)
			else
			begin
				errors++;
				$display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
			end
		end
	end

	// --------------------------------------------------
	// bus tasks
	// --------------------------------------------------
	task automatic tick();
		@(posedge S_AXI_ACLK);
		#0.5;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("ERROR: timed out waiting for %s", what);
		$display("TESTS FAILED");
		$finish;
	endtask

	function automatic void check_ctrl_regs();
		for (int i = 0; i < `GPU_REGS_NUM_CTRL; i++)
			expect_word(o_ctrl_regs[i], mirror[i], $sformatf("o_ctrl_regs[%0d]", i));
	endfunction

	task automatic start_write(input int idx, input gpu_regs_pkg::axi_data_t data,
		input gpu_regs_pkg::axi_strb_t strb);
		S_AXI_AWADDR  = gpu_regs_pkg::axi_addr_t'(idx) << `GPU_REGS_ADDR_LSB;
		S_AXI_WDATA   = data;
		S_AXI_WSTRB   = strb;
		S_AXI_AWVALID = 1'b1;
		S_AXI_WVALID  = 1'b1;
	endtask

	task automatic wait_write_ready();
		int n = 0;
		while (!(S_AXI_AWREADY && S_AXI_WREADY) && n < WAIT_LIMIT)
		begin
			tick();
			n++;
		end
		if (!(S_AXI_AWREADY && S_AXI_WREADY))
			abort_on_timeout("AWREADY and WREADY");
		tick(); // handshake edge
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID  = 1'b0;
	endtask

	function automatic void check_b_hold(input bit aw_blocked);
		assert (S_AXI_BVALID)
		else
		begin
			errors++;
			$display("ERROR: BVALID dropped while BREADY was low");
		end
		if (aw_blocked)
			assert (!S_AXI_AWREADY)
			else
			begin
				errors++;
				$display("ERROR: AWREADY rose while a write was outstanding");
			end
	endfunction

	task automatic finish_b(input int hold, input bit aw_blocked);
		int n = 0;
		while (!S_AXI_BVALID && n < WAIT_LIMIT)
		begin
			tick();
			n++;
		end
		if (!S_AXI_BVALID)
			abort_on_timeout("BVALID");
		for (int i = 0; i < hold; i++)
		begin
			tick();
			check_b_hold(aw_blocked);
		end
		S_AXI_BREADY = 1'b1;
		expect_word(32'(S_AXI_BRESP), 32'(gpu_regs_pkg::OKAY), "S_AXI_BRESP");
		tick();
		S_AXI_BREADY = 1'b0;
	endtask

	task automatic axi_write(input int idx, input gpu_regs_pkg::axi_data_t data,
		input gpu_regs_pkg::axi_strb_t strb);
		start_write(idx, data, strb);
		wait_write_ready();
		finish_b(0, 1'b0);
		mirror = ref_bank_write(mirror, idx, data, strb);
		check_ctrl_regs();
	endtask

	task automatic read_and_check(input int idx, input int hold);
		int n = 0;
		gpu_regs_pkg::axi_data_t first;
		S_AXI_ARADDR  = gpu_regs_pkg::axi_addr_t'(idx) << `GPU_REGS_ADDR_LSB;
		S_AXI_ARVALID = 1'b1;
		while (!S_AXI_ARREADY && n < WAIT_LIMIT)
		begin
			tick();
			n++;
		end
		if (!S_AXI_ARREADY)
			abort_on_timeout("ARREADY");
		tick();
		S_AXI_ARVALID = 1'b0;
		n = 0;
		while (!S_AXI_RVALID && n < WAIT_LIMIT)
		begin
			tick();
			n++;
		end
		if (!S_AXI_RVALID)
			abort_on_timeout("RVALID");
		first = S_AXI_RDATA;
		for (int i = 0; i < hold; i++)
		begin
			tick();
			assert (S_AXI_RVALID)
			else
			begin
				errors++;
				$display("ERROR: RVALID dropped while RREADY was low");
			end
			expect_word(S_AXI_RDATA, first, "S_AXI_RDATA (held)");
		end
		S_AXI_RREADY = 1'b1;
		expect_word(32'(S_AXI_RRESP), 32'(gpu_regs_pkg::OKAY), "S_AXI_RRESP");
		expect_word(S_AXI_RDATA, expected_read(idx), $sformatf("S_AXI_RDATA idx %0d", idx));
		tick();
		S_AXI_RREADY = 1'b0;
	endtask

	task automatic end_test(input string name);
		int n = 0;
		int errs;
		while (got_q.size() != 0 && n < WAIT_LIMIT)
		begin
			tick();
			n++;
		end
		if (got_q.size() != 0)
			abort_on_timeout("the comparison queue to drain");
		errs = total_errors() - test_err_start;
		test_count++;
		$display("test %0d %s: %s, %0d errors", test_count, name, errs == 0 ? "ok" : "bad", errs);
		test_err_start = total_errors();
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	initial
	begin : main
		gpu_regs_pkg::axi_data_t data, data2;
		gpu_regs_pkg::axi_strb_t strb, strb2;
		int idx, idx2, hold;
		S_AXI_ARESETN = 1'b0;
		{S_AXI_AWADDR, S_AXI_AWVALID, S_AXI_WDATA, S_AXI_WSTRB, S_AXI_WVALID} = '0;
		{S_AXI_BREADY, S_AXI_ARADDR, S_AXI_ARVALID, S_AXI_RREADY} = '0;
		status_words = '0;
		mirror = '0;
		repeat (10) @(posedge S_AXI_ACLK);
		#0.5;
		S_AXI_ARESETN = 1'b1;
		tick();

		assert (!S_AXI_AWREADY && !S_AXI_WREADY && !S_AXI_BVALID &&
			!S_AXI_ARREADY && !S_AXI_RVALID)
		else
		begin
			errors++;
			$display("ERROR: a ready or valid output is high after reset");
		end
		check_ctrl_regs();
		for (int i = 0; i < `GPU_REGS_NUM_CTRL; i++)
			read_and_check(i, 0);
		end_test("reset state");

		for (int i = 0; i < `GPU_REGS_NUM_CTRL; i++)
		begin
			data = rand_bits(32);
			axi_write(i, data, 4'hf);
			read_and_check(i, 0);
		end
		end_test("full-strobe writes");

		for (int i = 0; i < 32; i++)
		begin
			idx  = rand_bits(4);
			strb = gpu_regs_pkg::axi_strb_t'(rand_bits(4));
			data = rand_bits(32);
			axi_write(idx, data, strb);
			read_and_check(idx, 0);
		end
		end_test("strobed writes");

		for (int k = 16; k < 32; k++)
		begin
			status_words[k-16] = rand_bits(32);
			read_and_check(k, 0);
			strb = gpu_regs_pkg::axi_strb_t'(rand_bits(4));
			data = rand_bits(32);
			axi_write(k, data, strb); // must leave the bank alone
		end
		end_test("status words");

		for (int i = 0; i < 8; i++)
		begin
			idx   = rand_bits(4);
			data  = rand_bits(32);
			idx2  = rand_bits(4);
			data2 = rand_bits(32);
			strb2 = gpu_regs_pkg::axi_strb_t'(rand_bits(4));
			hold  = rand_bits(4);
			start_write(idx, data, 4'hf);
			wait_write_ready();
			start_write(idx2, data2, strb2); // issued before the B handshake
			finish_b(hold, 1'b1);
			mirror = ref_bank_write(mirror, idx, data, 4'hf);
			check_ctrl_regs();
			wait_write_ready();
			finish_b(0, 1'b0);
			mirror = ref_bank_write(mirror, idx2, data2, strb2);
			check_ctrl_regs();
			hold = rand_bits(4);
			read_and_check(idx2, hold);
			hold = rand_bits(4);
			read_and_check(16 + idx, hold);
		end
		end_test("back-pressure");

		$display("summary: %0d tests, %0d checks, %0d errors", test_count, checks, total_errors());
		if (total_errors() == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- project.f
+incdir+hw
hw/gpu_regs_pkg.sv
hw/gpu_regs_write_ctrl.sv
hw/gpu_regs_ctrl_bank.sv
hw/gpu_regs_read_ctrl.sv
hw/gpu_regs_top.sv
verif/gpu_regs_asserts.sv
verif/gpu_regs_tb.sv

//--- Bender.yml
package:
  name: gpu_regs

sources:
  - include_dirs:
      - hw
    files:
      - hw/gpu_regs_pkg.sv
      - hw/gpu_regs_write_ctrl.sv
      - hw/gpu_regs_ctrl_bank.sv
      - hw/gpu_regs_read_ctrl.sv
      - hw/gpu_regs_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - verif/gpu_regs_asserts.sv
      - verif/gpu_regs_tb.sv
